/* design/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  // Datapath sizes
  localparam int WordWidth   = 32;
  localparam int OpWidth     = 8;
  localparam int RegCount    = 16;
  localparam int RegIdxWidth = 4;   // Low nibble of each register byte
  localparam int PhaseWidth  = 4;
  localparam int WordBytes   = 4;   // IP step and stack step

  // Register roles
  localparam int SpReg   = 0;
  localparam int FlagReg = 1;       // Bit 0 equal, bit 1 less, bit 2 greater

  // Sequencer phases
  localparam logic [PhaseWidth-1:0] PhFetch     = 4'd0;
  localparam logic [PhaseWidth-1:0] PhFetchWait = 4'd1;
  localparam logic [PhaseWidth-1:0] PhDecode    = 4'd2;
  localparam logic [PhaseWidth-1:0] PhOperand   = 4'd3;
  localparam logic [PhaseWidth-1:0] PhConst     = 4'd4;
  localparam logic [PhaseWidth-1:0] PhConstWait = 4'd5;
  localparam logic [PhaseWidth-1:0] PhMem       = 4'd6;
  localparam logic [PhaseWidth-1:0] PhMemWait   = 4'd7;
  localparam logic [PhaseWidth-1:0] PhMemDone   = 4'd8;
  localparam logic [PhaseWidth-1:0] PhExecute   = 4'd9;

  // Moves, loads and stores
  localparam logic [OpWidth-1:0] OpMovRC   = 8'd1;
  localparam logic [OpWidth-1:0] OpMovRR   = 8'd2;
  localparam logic [OpWidth-1:0] OpMovRdC  = 8'd3;
  localparam logic [OpWidth-1:0] OpMovRdR  = 8'd4;
  localparam logic [OpWidth-1:0] OpMovRdRo = 8'd5;
  localparam logic [OpWidth-1:0] OpMovdCR  = 8'd6;
  localparam logic [OpWidth-1:0] OpMovdRoR = 8'd7;
  // Stack
  localparam logic [OpWidth-1:0] OpPushR   = 8'd8;
  localparam logic [OpWidth-1:0] OpPopR    = 8'd9;
  localparam logic [OpWidth-1:0] OpCallR   = 8'd10;
  localparam logic [OpWidth-1:0] OpRet     = 8'd11;
  // Jumps
  localparam logic [OpWidth-1:0] OpJmpC    = 8'd12;
  localparam logic [OpWidth-1:0] OpJeC     = 8'd13;
  localparam logic [OpWidth-1:0] OpJneC    = 8'd14;
  localparam logic [OpWidth-1:0] OpJzRC    = 8'd15;
  localparam logic [OpWidth-1:0] OpJnzRC   = 8'd16;
  // Compare and integer math
  localparam logic [OpWidth-1:0] OpCmpRR   = 8'd17;
  localparam logic [OpWidth-1:0] OpCmpRC   = 8'd18;
  localparam logic [OpWidth-1:0] OpAddRRR  = 8'd19;
  localparam logic [OpWidth-1:0] OpAddRRC  = 8'd20;
  localparam logic [OpWidth-1:0] OpSubRRR  = 8'd21;
  localparam logic [OpWidth-1:0] OpSubRRC  = 8'd22;
  localparam logic [OpWidth-1:0] OpIncR    = 8'd23;
  localparam logic [OpWidth-1:0] OpDecR    = 8'd24;
  localparam logic [OpWidth-1:0] OpShlRRR  = 8'd25;
  localparam logic [OpWidth-1:0] OpShrRRR  = 8'd26;
  localparam logic [OpWidth-1:0] OpNegRR   = 8'd27;
  localparam logic [OpWidth-1:0] OpStall   = 8'd28;

  // Instructions followed by a constant word
  function automatic logic isTwoWord(input logic [OpWidth-1:0] op);
    case (op)
      OpMovRC, OpMovRdC, OpMovRdRo, OpMovdCR, OpMovdRoR,
      OpJmpC, OpJeC, OpJneC, OpJzRC, OpJnzRC,
      OpCmpRC, OpAddRRC, OpSubRRC: isTwoWord = 1'b1;
      default:                     isTwoWord = 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

/* design/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire  [cpuPkg::WordWidth-1:0]        ramIn,
  input  wire                                 fetchLatch,
  input  wire                                 constLatch,
  output logic [cpuPkg::OpWidth-1:0]          opcode,
  output logic [cpuPkg::RegIdxWidth-1:0]      regA,
  output logic [cpuPkg::RegIdxWidth-1:0]      regB,
  output logic [cpuPkg::RegIdxWidth-1:0]      regC,
  output logic [cpuPkg::WordWidth-1:0]        constWord,
  output logic                                hasConst,
  output logic                                memRead,
  output logic                                memWrite
);

  // Instruction fields
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      opcode <= '0;  // Zero decodes as a no-op
      regA   <= '0;
      regB   <= '0;
      regC   <= '0;
    end else if (fetchLatch) begin
      opcode <= ramIn[7:0];
      regA   <= ramIn[8 +: cpuPkg::RegIdxWidth];   // Upper nibble of each field ignored
      regB   <= ramIn[16 +: cpuPkg::RegIdxWidth];
      regC   <= ramIn[24 +: cpuPkg::RegIdxWidth];
    end
  end

  always_ff @(posedge clk) begin
    if (constLatch) constWord <= ramIn;  // Second word
  end

  assign hasConst = cpuPkg::isTwoWord(opcode);

  // Data access classes
  assign memRead  = (opcode == cpuPkg::OpMovRdC) || (opcode == cpuPkg::OpMovRdR) ||
                    (opcode == cpuPkg::OpMovRdRo) || (opcode == cpuPkg::OpPopR) ||
                    (opcode == cpuPkg::OpRet);
  assign memWrite = (opcode == cpuPkg::OpMovdCR) || (opcode == cpuPkg::OpMovdRoR) ||
                    (opcode == cpuPkg::OpPushR) || (opcode == cpuPkg::OpCallR);

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire                             clk,
  input  wire                             reset,
  input  wire  [cpuPkg::RegIdxWidth-1:0]  regA,
  input  wire  [cpuPkg::RegIdxWidth-1:0]  regB,
  input  wire  [cpuPkg::RegIdxWidth-1:0]  regC,
  input  wire                             operandLatch,
  input  wire                             execute,
  input  wire                             wrEn,
  input  wire  [cpuPkg::RegIdxWidth-1:0]  wrIdx,
  input  wire  [cpuPkg::WordWidth-1:0]    wrData,
  input  wire                             flagsWrite,
  input  wire  [2:0]                      flagsOut,
  input  wire  [1:0]                      spStep,     // 0 none, 1 up, 2 down
  output logic [cpuPkg::WordWidth-1:0]    opA,
  output logic [cpuPkg::WordWidth-1:0]    opB,
  output logic [cpuPkg::WordWidth-1:0]    opC,
  output logic [cpuPkg::WordWidth-1:0]    spValue,
  output logic                            flagEq
);

  logic [cpuPkg::WordWidth-1:0] regs [cpuPkg::RegCount];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < cpuPkg::RegCount; i++) regs[i] <= '0;
    end else if (execute) begin
      if (wrEn) regs[wrIdx] <= wrData;
      if (flagsWrite) regs[cpuPkg::FlagReg] <= {{(cpuPkg::WordWidth-3){1'b0}}, flagsOut};
      // SP step last so it overrides a write to r0
      if (spStep == 2'd1) regs[cpuPkg::SpReg] <= regs[cpuPkg::SpReg] + cpuPkg::WordBytes;
      else if (spStep == 2'd2) regs[cpuPkg::SpReg] <= regs[cpuPkg::SpReg] - cpuPkg::WordBytes;
    end
  end

  // Operand snapshot for the rest of the instruction
  always_ff @(posedge clk) begin
    if (operandLatch) begin
      opA <= regs[regA];
      opB <= regs[regB];
      opC <= regs[regC];
    end
  end

  assign spValue = regs[cpuPkg::SpReg];
  assign flagEq  = regs[cpuPkg::FlagReg][0];

endmodule

`default_nettype wire

/* design/intAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module intAlu (
  input  wire  [cpuPkg::OpWidth-1:0]      opcode,
  input  wire  [cpuPkg::WordWidth-1:0]    opA,
  input  wire  [cpuPkg::WordWidth-1:0]    opB,
  input  wire  [cpuPkg::WordWidth-1:0]    opC,
  input  wire  [cpuPkg::WordWidth-1:0]    constWord,
  input  wire  [cpuPkg::WordWidth-1:0]    loadData,
  input  wire  [cpuPkg::RegIdxWidth-1:0]  regA,
  output logic [cpuPkg::WordWidth-1:0]    wrData,
  output logic                            wrEn,
  output logic                            flagsWrite,
  output logic [2:0]                      flagsOut,
  output logic [1:0]                      spStep,
  output logic [cpuPkg::RegIdxWidth-1:0]  wrIdx
);

  logic [cpuPkg::WordWidth-1:0] cmpRhs;

  // Register result
  always_comb begin
    wrEn = 1'b1;
    case (opcode)
      cpuPkg::OpMovRC:   wrData = constWord;
      cpuPkg::OpMovRR:   wrData = opB;
      cpuPkg::OpMovRdC,
      cpuPkg::OpMovRdR,
      cpuPkg::OpMovRdRo,
      cpuPkg::OpPopR:    wrData = loadData;   // Captured RAM word
      cpuPkg::OpAddRRR:  wrData = opB + opC;
      cpuPkg::OpAddRRC:  wrData = opB + constWord;
      cpuPkg::OpSubRRR:  wrData = opB - opC;
      cpuPkg::OpSubRRC:  wrData = opB - constWord;
      cpuPkg::OpIncR:    wrData = opA + 1'b1;
      cpuPkg::OpDecR:    wrData = opA - 1'b1;
      cpuPkg::OpShlRRR:  wrData = opB << opC;
      cpuPkg::OpShrRRR:  wrData = opB >> opC;
      cpuPkg::OpNegRR:   wrData = -opB;
      default: begin
        wrData = opB;
        wrEn   = 1'b0;   // No register update
      end
    endcase
  end

  assign wrIdx = regA;   // Destination always field A

  // Unsigned compare of A against B or the constant
  assign cmpRhs     = (opcode == cpuPkg::OpCmpRC) ? constWord : opB;
  assign flagsOut   = {opA > cmpRhs, opA < cmpRhs, opA == cmpRhs};
  assign flagsWrite = (opcode == cpuPkg::OpCmpRR) || (opcode == cpuPkg::OpCmpRC);

  // Stack grows upward
  assign spStep = (opcode == cpuPkg::OpPushR || opcode == cpuPkg::OpCallR) ? 2'd1 :
                  (opcode == cpuPkg::OpPopR  || opcode == cpuPkg::OpRet)   ? 2'd2 : 2'd0;

endmodule

`default_nettype wire

/* design/memPort.sv */
`timescale 1ns/1ps
`default_nettype none

module memPort (
  input  wire                           clk,
  input  wire                           reset,
  input  wire  [cpuPkg::OpWidth-1:0]    opcode,
  input  wire  [cpuPkg::WordWidth-1:0]  opA,
  input  wire  [cpuPkg::WordWidth-1:0]  opB,
  input  wire  [cpuPkg::WordWidth-1:0]  constWord,
  input  wire  [cpuPkg::WordWidth-1:0]  spValue,
  input  wire  [cpuPkg::WordWidth-1:0]  ipointer,
  input  wire                           fetchLatch,
  input  wire                           memIssue,
  input  wire                           memCapture,
  input  wire                           execute,
  input  wire  [cpuPkg::WordWidth-1:0]  ramIn,
  output logic [cpuPkg::WordWidth-1:0]  ramAddress,
  output logic [cpuPkg::WordWidth-1:0]  ramOut,
  output logic [cpuPkg::WordWidth-1:0]  loadData
);

  logic [1:0]                   addrSel;   // 0 instruction, 1 constant, 2 data
  logic [cpuPkg::WordWidth-1:0] dataAddr;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) addrSel <= 2'd0;
    else if (execute) addrSel <= 2'd0;
    else if (fetchLatch) addrSel <= 2'd1;   // Next read is the constant word
    else if (memIssue) addrSel <= 2'd2;
  end

  // Data address and store word
  always_ff @(posedge clk) begin
    if (memIssue) begin
      case (opcode)
        cpuPkg::OpMovRdR:  dataAddr <= opB;
        cpuPkg::OpMovRdRo: dataAddr <= constWord + opB;
        cpuPkg::OpMovdRoR: dataAddr <= constWord + opA;
        cpuPkg::OpPushR,
        cpuPkg::OpCallR:   dataAddr <= spValue;   // SP points at free slot
        cpuPkg::OpPopR,
        cpuPkg::OpRet:     dataAddr <= spValue - cpuPkg::WordBytes;
        default:           dataAddr <= constWord;   // MovRdC, MovdCR
      endcase
      if (opcode == cpuPkg::OpPushR) ramOut <= opA;
      else if (opcode == cpuPkg::OpCallR) ramOut <= ipointer;   // Return address
      else ramOut <= opB;
    end
    if (memCapture) loadData <= ramIn;
  end

  always_comb begin
    case (addrSel)
      2'd1:    ramAddress = ipointer + cpuPkg::WordBytes;
      2'd2:    ramAddress = dataAddr;
      default: ramAddress = ipointer;
    endcase
  end

endmodule

`default_nettype wire

/* design/pcUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
  input  wire                           clk,
  input  wire                           reset,
  input  wire  [cpuPkg::OpWidth-1:0]    opcode,
  input  wire                           hasConst,
  input  wire  [cpuPkg::WordWidth-1:0]  constWord,
  input  wire  [cpuPkg::WordWidth-1:0]  opA,
  input  wire  [cpuPkg::WordWidth-1:0]  opC,
  input  wire  [cpuPkg::WordWidth-1:0]  loadData,
  input  wire                           flagEq,
  input  wire                           execute,
  output logic [cpuPkg::WordWidth-1:0]  ipointer
);

  logic                         jumpTaken;
  logic [cpuPkg::WordWidth-1:0] nextIp;

  // Branch condition
  always_comb begin
    case (opcode)
      cpuPkg::OpJmpC:  jumpTaken = 1'b1;
      cpuPkg::OpJeC:   jumpTaken = flagEq;
      cpuPkg::OpJneC:  jumpTaken = !flagEq;
      cpuPkg::OpJzRC:  jumpTaken = (opC == '0);
      cpuPkg::OpJnzRC: jumpTaken = (opC != '0);
      default:         jumpTaken = 1'b0;
    endcase
  end

  always_comb begin
    if (jumpTaken) nextIp = constWord;
    else if (opcode == cpuPkg::OpCallR) nextIp = opA;
    else if (opcode == cpuPkg::OpRet) nextIp = loadData + cpuPkg::WordBytes;   // Skip the call
    else if (opcode == cpuPkg::OpStall) nextIp = ipointer;   // Spin here
    else if (hasConst) nextIp = ipointer + 2 * cpuPkg::WordBytes;
    else nextIp = ipointer + cpuPkg::WordBytes;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) ipointer <= '0;
    else if (execute) ipointer <= nextIp;
  end

endmodule

`default_nettype wire

/* design/seqControl.sv */
`timescale 1ns/1ps
`default_nettype none

module seqControl (
  input  wire   clk,
  input  wire   reset,
  input  wire   hasConst,
  input  wire   memRead,
  input  wire   memWrite,
  output logic  readReq,
  output logic  writeReq,
  output logic  fetchLatch,
  output logic  operandLatch,
  output logic  constLatch,
  output logic  memIssue,
  output logic  memCapture,
  output logic  execute
);

  logic [cpuPkg::PhaseWidth-1:0] phase;
  logic [cpuPkg::PhaseWidth-1:0] nextPhase;
  logic                          armed;   // First fetch request issued
  logic                          memOp;

  assign memOp = memRead || memWrite;

  always_comb begin
    case (phase)
      cpuPkg::PhFetch:     nextPhase = armed ? cpuPkg::PhFetchWait : cpuPkg::PhFetch;
      cpuPkg::PhFetchWait: nextPhase = cpuPkg::PhDecode;
      cpuPkg::PhDecode:    nextPhase = cpuPkg::PhOperand;
      cpuPkg::PhOperand:   nextPhase = hasConst ? cpuPkg::PhConst :
                                       memOp    ? cpuPkg::PhMem : cpuPkg::PhExecute;
      cpuPkg::PhConst:     nextPhase = cpuPkg::PhConstWait;
      cpuPkg::PhConstWait: nextPhase = memOp ? cpuPkg::PhMem : cpuPkg::PhExecute;
      cpuPkg::PhMem:       nextPhase = cpuPkg::PhMemWait;
      cpuPkg::PhMemWait:   nextPhase = cpuPkg::PhMemDone;
      cpuPkg::PhMemDone:   nextPhase = cpuPkg::PhExecute;
      default:             nextPhase = cpuPkg::PhFetch;   // Execute and unused codes
    endcase
  end

  // RAM strobes registered, high for the whole phase they belong to
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase    <= cpuPkg::PhFetch;
      armed    <= 1'b0;
      readReq  <= 1'b0;
      writeReq <= 1'b0;
    end else begin
      phase    <= nextPhase;
      armed    <= 1'b1;
      readReq  <= (nextPhase == cpuPkg::PhFetch && phase != cpuPkg::PhFetch) ||
                  (phase == cpuPkg::PhFetch && !armed) ||
                  (nextPhase == cpuPkg::PhConst) ||
                  (phase == cpuPkg::PhMem && memRead);   // Data read lands in MemWait
      writeReq <= (phase == cpuPkg::PhMem) && memWrite;
    end
  end

  // Datapath strobes
  assign fetchLatch   = (phase == cpuPkg::PhDecode);
  assign operandLatch = (phase == cpuPkg::PhOperand);
  assign constLatch   = (phase == cpuPkg::PhConstWait);
  assign memIssue     = (phase == cpuPkg::PhMem);
  assign memCapture   = (phase == cpuPkg::PhMemDone);
  assign execute      = (phase == cpuPkg::PhExecute);

endmodule

`default_nettype wire

/* design/cpuCore.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
  input  wire                           clk,
  input  wire                           reset,
  input  wire  [cpuPkg::WordWidth-1:0]  ramIn,
  output logic [cpuPkg::WordWidth-1:0]  ramAddress,
  output logic [cpuPkg::WordWidth-1:0]  ramOut,
  output logic                          readReq,
  output logic                          writeReq
);

  // Phase strobes
  logic fetchLatch, operandLatch, constLatch, memIssue, memCapture, execute;
  // Decoded instruction
  logic [cpuPkg::OpWidth-1:0]     opcode;
  logic [cpuPkg::RegIdxWidth-1:0] regA, regB, regC, wrIdx;
  logic [cpuPkg::WordWidth-1:0]   constWord;
  logic                           hasConst, memRead, memWrite;
  // Datapath
  logic [cpuPkg::WordWidth-1:0]   opA, opB, opC, spValue, wrData, loadData, ipointer;
  logic                           flagEq, wrEn, flagsWrite;
  logic [2:0]                     flagsOut;
  logic [1:0]                     spStep;

  seqControl seq_i (
    .clk, .reset, .hasConst, .memRead, .memWrite, .readReq, .writeReq,
    .fetchLatch, .operandLatch, .constLatch, .memIssue, .memCapture, .execute
  );

  instrDecode dec_i (
    .clk, .reset, .ramIn, .fetchLatch, .constLatch, .opcode, .regA, .regB, .regC,
    .constWord, .hasConst, .memRead, .memWrite
  );

  regFile regs_i (
    .clk, .reset, .regA, .regB, .regC, .operandLatch, .execute, .wrEn, .wrIdx,
    .wrData, .flagsWrite, .flagsOut, .spStep, .opA, .opB, .opC, .spValue, .flagEq
  );

  intAlu alu_i (
    .opcode, .opA, .opB, .opC, .constWord, .loadData, .regA, .wrData, .wrEn,
    .flagsWrite, .flagsOut, .spStep, .wrIdx
  );

  memPort mem_i (
    .clk, .reset, .opcode, .opA, .opB, .constWord, .spValue, .ipointer, .fetchLatch,
    .memIssue, .memCapture, .execute, .ramIn, .ramAddress, .ramOut, .loadData
  );

  pcUnit pc_i (
    .clk, .reset, .opcode, .hasConst, .constWord, .opA, .opC, .loadData, .flagEq,
    .execute, .ipointer
  );

endmodule

`default_nettype wire

/* tb/tbRam.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRam #(
  parameter int Words = 1024
) (
  input  wire                           clk,
  input  wire                           readReq,
  input  wire                           writeReq,
  input  wire  [cpuPkg::WordWidth-1:0]  address,
  input  wire  [cpuPkg::WordWidth-1:0]  writeData,
  output logic [cpuPkg::WordWidth-1:0]  readData
);

  localparam int IdxWidth = $clog2(Words);

  logic [cpuPkg::WordWidth-1:0] mem [Words];
  logic [cpuPkg::WordWidth-1:0] writeAddr [$];   // Store log, in order
  logic [cpuPkg::WordWidth-1:0] writeWord [$];
  logic [IdxWidth-1:0]          rdIdx;

  initial readData = '0;

  always @(posedge clk) begin
    if (writeReq) begin
      mem[address[2 +: IdxWidth]] = writeData;
      writeAddr.push_back(address);
      writeWord.push_back(writeData);
    end
    if (readReq) begin
      rdIdx = address[2 +: IdxWidth];   // Address taken at the edge
      #1 readData = mem[rdIdx];         // Held until the next read
    end
  end

endmodule

`default_nettype wire

/* tb/cpuCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

  localparam int RamWords      = 1024;
  localparam int TimeoutCycles = 3000;

  logic                          clk;
  logic                          reset;
  logic [cpuPkg::WordWidth-1:0]  ramIn, ramAddress, ramOut;
  logic                          readReq, writeReq;

  logic [31:0] prog [$];                      // Program image, word 0 at address 0
  logic [31:0] presetAddr [$], presetData [$];
  logic [31:0] expAddr [$], expData [$];      // Expected stores in order
  logic [31:0] readAddrLog [$];
  int          readCycleLog [$];
  int          cycleCount;
  logic [31:0] stallAddr;
  logic [31:0] rngState = 32'd51;

  cpuCore dut_i (.clk, .reset, .ramIn, .ramAddress, .ramOut, .readReq, .writeReq);

  tbRam #(.Words(RamWords)) ram_i (
    .clk, .readReq, .writeReq, .address(ramAddress), .writeData(ramOut), .readData(ramIn)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Read strobes logged mid-cycle with their cycle number
  always @(negedge clk) begin
    if (reset) cycleCount = 0;
    else begin
      cycleCount++;
      if (readReq) begin
        readAddrLog.push_back(ramAddress);
        readCycleLog.push_back(cycleCount);
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  task automatic drawWord(output logic [31:0] w);
    rngState = xorshift32(rngState);
    w = rngState;
  endtask

  task automatic abortRun();
    $display("Testbench failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("ERR at %0t ns: %s got %h expected %h", $time, name, got, want);
      abortRun();
    end
  endtask

  function automatic logic [31:0] nextAddr();
    return prog.size() * 4;
  endfunction

  task automatic newProgram();
    prog.delete();
    presetAddr.delete();
    presetData.delete();
    expAddr.delete();
    expData.delete();
  endtask

  // Opcode in byte 0, register fields A, B, C above it
  task automatic emit(input logic [7:0] op, input int a, input int b, input int c);
    if (op == cpuPkg::OpStall) stallAddr = nextAddr();
    prog.push_back({c[7:0], b[7:0], a[7:0], op});
  endtask

  task automatic emitConst(input logic [7:0] op, input int a, input int b, input int c,
                           input logic [31:0] k);
    emit(op, a, b, c);
    prog.push_back(k);   // Second word
  endtask

  task automatic presetWord(input logic [31:0] addr, input logic [31:0] data);
    presetAddr.push_back(addr);
    presetData.push_back(data);
  endtask

  task automatic expectWrite(input logic [31:0] addr, input logic [31:0] data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // Image goes in while the core is held in reset
  task automatic loadAndReset();
    @(posedge clk);
    #1 reset = 1'b1;
    for (int i = 0; i < RamWords; i++) ram_i.mem[i] = '0;
    foreach (prog[i]) ram_i.mem[i] = prog[i];
    foreach (presetAddr[i]) ram_i.mem[presetAddr[i] >> 2] = presetData[i];
    ram_i.writeAddr.delete();
    ram_i.writeWord.delete();
    readAddrLog.delete();
    readCycleLog.delete();
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  function automatic int readsAt(input logic [31:0] addr);
    int n;
    n = 0;
    foreach (readAddrLog[i]) if (readAddrLog[i] == addr) n++;
    return n;
  endfunction

  task automatic runToStall(input int fetches);
    int cycles;
    cycles = 0;
    while (readsAt(stallAddr) < fetches && cycles < TimeoutCycles) begin
      @(posedge clk);
      #1 cycles++;
    end
    if (readsAt(stallAddr) < fetches) begin
      $display("Timeout: the core never spun on its stall instruction");
      abortRun();
    end
  endtask

  task automatic checkWrites();
    checkValue("write count", ram_i.writeAddr.size(), expAddr.size());
    foreach (expAddr[i]) begin
      checkValue($sformatf("ramAddress of write %0d", i), ram_i.writeAddr[i], expAddr[i]);
      checkValue($sformatf("ramOut of write %0d", i), ram_i.writeWord[i], expData[i]);
    end
  endtask

  task automatic idleAfterReset();
    int cycles;
    newProgram();
    emit(cpuPkg::OpStall, 0, 0, 0);
    loadAndReset();
    checkValue("readReq", readReq, 1'b0);
    checkValue("writeReq", writeReq, 1'b0);
    cycles = 0;
    while (readAddrLog.size() == 0 && cycles < TimeoutCycles) begin
      @(posedge clk);
      #1 cycles++;
    end
    if (readAddrLog.size() == 0) begin
      $display("Timeout: no read request came after reset");
      abortRun();
    end
    checkValue("first ramAddress", readAddrLog[0], 32'h0);
    runToStall(2);
    checkWrites();
  endtask

  task automatic arithmeticOps();
    logic [31:0] x, y, s, k;
    drawWord(x);
    drawWord(y);
    drawWord(s);
    drawWord(k);
    s = s & 32'd31;   // Shift distance
    newProgram();
    emitConst(cpuPkg::OpMovRC, 2, 0, 0, x);
    emitConst(cpuPkg::OpMovRC, 3, 0, 0, y);
    emitConst(cpuPkg::OpMovRC, 4, 0, 0, s);
    emit(cpuPkg::OpAddRRR, 5, 2, 3);
    emitConst(cpuPkg::OpSubRRC, 6, 2, 0, k);
    emit(cpuPkg::OpMovRR, 7, 2, 0);
    emit(cpuPkg::OpIncR, 7, 0, 0);
    emit(cpuPkg::OpMovRR, 8, 3, 0);
    emit(cpuPkg::OpDecR, 8, 0, 0);
    emit(cpuPkg::OpShlRRR, 9, 2, 4);
    emit(cpuPkg::OpShrRRR, 10, 3, 4);
    emit(cpuPkg::OpNegRR, 11, 2, 0);
    for (int r = 5; r <= 11; r++) emitConst(cpuPkg::OpMovdCR, 0, r, 0, 32'h400 + (r - 5) * 4);
    emit(cpuPkg::OpStall, 0, 0, 0);
    expectWrite(32'h400, x + y);
    expectWrite(32'h404, x - k);
    expectWrite(32'h408, x + 1);
    expectWrite(32'h40C, y - 1);
    expectWrite(32'h410, x << s);
    expectWrite(32'h414, y >> s);
    expectWrite(32'h418, -x);
    loadAndReset();
    runToStall(2);
    checkWrites();
  endtask

  task automatic loadForms();
    logic [31:0] p0, p1, p2;
    drawWord(p0);
    drawWord(p1);
    drawWord(p2);
    newProgram();
    presetWord(32'h500, p0);
    presetWord(32'h504, p1);
    presetWord(32'h508, p2);
    emitConst(cpuPkg::OpMovRdC, 2, 0, 0, 32'h500);
    emitConst(cpuPkg::OpMovRC, 3, 0, 0, 32'h504);
    emit(cpuPkg::OpMovRdR, 4, 3, 0);
    emitConst(cpuPkg::OpMovRC, 5, 0, 0, 32'h500);
    emitConst(cpuPkg::OpMovRdRo, 6, 5, 0, 32'h8);     // Base plus offset
    emitConst(cpuPkg::OpMovdCR, 0, 2, 0, 32'h600);
    emitConst(cpuPkg::OpMovdRoR, 5, 4, 0, 32'h104);   // Lands on 0x604
    emitConst(cpuPkg::OpMovdCR, 0, 6, 0, 32'h608);
    emit(cpuPkg::OpStall, 0, 0, 0);
    expectWrite(32'h600, p0);
    expectWrite(32'h604, p1);
    expectWrite(32'h608, p2);
    loadAndReset();
    runToStall(2);
    checkWrites();
  endtask

  task automatic stackAndCall();
    logic [31:0] v, marker, callAddr;
    int          subConst;
    drawWord(v);
    drawWord(marker);
    newProgram();
    emitConst(cpuPkg::OpMovRC, 0, 0, 0, 32'h700);   // Stack base
    emitConst(cpuPkg::OpMovRC, 2, 0, 0, v);
    emit(cpuPkg::OpPushR, 2, 0, 0);
    emitConst(cpuPkg::OpMovRC, 2, 0, 0, 32'h0);     // Clobber the source
    emit(cpuPkg::OpPopR, 3, 0, 0);
    emitConst(cpuPkg::OpMovdCR, 0, 3, 0, 32'h800);
    emitConst(cpuPkg::OpMovdCR, 0, 0, 0, 32'h804);
    subConst = prog.size() + 1;
    emitConst(cpuPkg::OpMovRC, 4, 0, 0, 32'h0);     // Subroutine address patched below
    callAddr = nextAddr();
    emit(cpuPkg::OpCallR, 4, 0, 0);
    emitConst(cpuPkg::OpMovdCR, 0, 5, 0, 32'h808);  // Marker after the call site
    emitConst(cpuPkg::OpMovdCR, 0, 0, 0, 32'h80C);
    emit(cpuPkg::OpStall, 0, 0, 0);
    prog[subConst] = nextAddr();
    emitConst(cpuPkg::OpMovRC, 5, 0, 0, marker);
    emit(cpuPkg::OpRet, 0, 0, 0);
    expectWrite(32'h700, v);
    expectWrite(32'h800, v);
    expectWrite(32'h804, 32'h700);
    expectWrite(32'h700, callAddr);   // Return slot
    expectWrite(32'h808, marker);
    expectWrite(32'h80C, 32'h700);
    loadAndReset();
    runToStall(2);
    checkWrites();
  endtask

  // Jump over one marker store, which only shows when the jump falls through
  task automatic jumpCase(input logic [7:0] op, input int regC, input bit taken,
                          input logic [31:0] storeAddr, input logic [31:0] marker);
    emitConst(op, 0, 0, regC, nextAddr() + 16);
    emitConst(cpuPkg::OpMovdCR, 0, 6, 0, storeAddr);
    if (!taken) expectWrite(storeAddr, marker);
  endtask

  task automatic branchPaths();
    logic [31:0] a, b, marker, flags;
    drawWord(a);
    drawWord(b);
    drawWord(marker);
    a = a | 32'h100;           // Never zero
    b = a ^ (b | 32'h1);       // Never equal to a
    flags = '0;
    flags[2] = a > b;
    flags[1] = a < b;
    newProgram();
    emitConst(cpuPkg::OpMovRC, 2, 0, 0, a);
    emitConst(cpuPkg::OpMovRC, 3, 0, 0, a);
    emitConst(cpuPkg::OpMovRC, 4, 0, 0, b);
    emitConst(cpuPkg::OpMovRC, 6, 0, 0, marker);
    emitConst(cpuPkg::OpMovRC, 7, 0, 0, 32'h0);
    emit(cpuPkg::OpCmpRR, 2, 3, 0);
    jumpCase(cpuPkg::OpJeC, 0, 1'b1, 32'h900, marker);
    jumpCase(cpuPkg::OpJneC, 0, 1'b0, 32'h904, marker);
    emit(cpuPkg::OpCmpRR, 2, 4, 0);
    emitConst(cpuPkg::OpMovdCR, 0, 1, 0, 32'h908);   // Flag register
    expectWrite(32'h908, flags);
    jumpCase(cpuPkg::OpJeC, 0, 1'b0, 32'h90C, marker);
    jumpCase(cpuPkg::OpJneC, 0, 1'b1, 32'h910, marker);
    emitConst(cpuPkg::OpCmpRC, 2, 0, 0, a);
    jumpCase(cpuPkg::OpJeC, 0, 1'b1, 32'h914, marker);
    emitConst(cpuPkg::OpCmpRC, 2, 0, 0, a ^ 32'h1);
    jumpCase(cpuPkg::OpJneC, 0, 1'b1, 32'h918, marker);
    jumpCase(cpuPkg::OpJeC, 0, 1'b0, 32'h91C, marker);
    jumpCase(cpuPkg::OpJzRC, 7, 1'b1, 32'h920, marker);
    jumpCase(cpuPkg::OpJzRC, 2, 1'b0, 32'h924, marker);
    jumpCase(cpuPkg::OpJnzRC, 2, 1'b1, 32'h928, marker);
    jumpCase(cpuPkg::OpJnzRC, 7, 1'b0, 32'h92C, marker);
    emit(cpuPkg::OpStall, 0, 0, 0);
    loadAndReset();
    runToStall(2);
    checkWrites();
  endtask

  task automatic fetchTiming();
    logic [31:0] wantAddr [$];
    int          wantGap [$];
    int          fetchAt [$];
    int          k;
    wantAddr = '{32'd0, 32'd8, 32'd12, 32'd20, 32'd24, 32'd24, 32'd24};
    wantGap  = '{7, 5, 10, 8, 5, 5};   // Constant 7, plain 5, both 10, memory 8
    newProgram();
    emitConst(cpuPkg::OpMovRC, 2, 0, 0, 32'h300);
    emit(cpuPkg::OpAddRRR, 3, 2, 2);
    emitConst(cpuPkg::OpMovdCR, 0, 3, 0, 32'h300);
    emit(cpuPkg::OpMovRdR, 4, 2, 0);
    emit(cpuPkg::OpStall, 0, 0, 0);
    expectWrite(32'h300, 32'h600);
    loadAndReset();
    runToStall(3);
    checkWrites();
    // Pick out instruction fetches, skipping constant and data reads
    k = 0;
    foreach (readAddrLog[j]) begin
      if (k < wantAddr.size() && readAddrLog[j] == wantAddr[k]) begin
        fetchAt.push_back(readCycleLog[j]);
        k++;
      end
    end
    checkValue("fetch count", k, wantAddr.size());
    foreach (wantGap[i])
      checkValue($sformatf("fetch gap %0d", i), fetchAt[i + 1] - fetchAt[i], wantGap[i]);
  endtask

  initial begin
    reset = 1'b1;
    idleAfterReset();
    arithmeticOps();
    loadForms();
    stackAndCall();
    branchPaths();
    fetchTiming();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
design/cpuPkg.sv
design/instrDecode.sv
design/regFile.sv
design/intAlu.sv
design/memPort.sv
design/pcUnit.sv
design/seqControl.sv
design/cpuCore.sv
tb/tbRam.sv
tb/cpuCoreTb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - design/cpuPkg.sv
      - design/instrDecode.sv
      - design/regFile.sv
      - design/intAlu.sv
      - design/memPort.sv
      - design/pcUnit.sv
      - design/seqControl.sv
      - design/cpuCore.sv
  - target: test
    files:
      - tb/tbRam.sv
      - tb/cpuCoreTb.sv
